//--- hw/epu_msr_pkg.sv
// MSR map of the exception unit
// Bank codes, PS-bank offsets and PSR field positions
package epu_msr_pkg;

   // Immediate bits ORed into the MSR address
   localparam int MSR_IMM_W = 15;

   // Address split into bank number and offset inside the bank
   localparam int BANK_AW = 4;
   localparam int BANK_OFF_AW = 9;

   typedef logic [BANK_AW-1:0] msr_bank_t;

   // Offsets are decoded one-hot style, one bit per register
   typedef logic [BANK_OFF_AW-1:0] msr_off_t;

   // Banks kept in this unit
   localparam msr_bank_t BANK_PS = 4'd0;
   localparam msr_bank_t BANK_SR = 4'd8;

   // Processor-status bank offset bits
   localparam int OFF_PSR = 0;
   localparam int OFF_CPUID = 1;
   localparam int OFF_EPSR = 2;
   localparam int OFF_EPC = 3;
   localparam int OFF_ELSA = 4;
   localparam int OFF_COREID = 5;

   // PSR width as stored by the register file
   localparam int PSR_W = 10;

   typedef logic [PSR_W-1:0] psr_t;

   // Writable PSR fields, bit positions in the written word
   localparam int PSR_RM = 4;
   localparam int PSR_IRE = 5;
   localparam int PSR_IMME = 6;
   localparam int PSR_DMME = 7;
   localparam int PSR_ICE = 8;
   localparam int PSR_DCE = 9;

endpackage

//--- hw/epu_exc_pkg.sv
// EPU opcode bus and commit-stage control
// Decisions made in stage one and carried into stage two
package epu_exc_pkg;

   localparam int OPC_W = 6;

   typedef logic [OPC_W-1:0] epu_opc_t;

   // Opcode bus bits, at most one set per instruction
   localparam int OPC_RMSR = 0;
   localparam int OPC_WMSR = 1;
   localparam int OPC_ERET = 2;
   localparam int OPC_ESYSCALL = 3;
   localparam int OPC_EINSN = 4;
   localparam int OPC_EIRQ = 5;

   // Stage-one decisions that cross the stage boundary
   typedef struct packed {
      logic eret;
      logic esyscall;
      logic einsn;
      logic eirq;
      // PSR write needs a pipeline flush and TLB resync
      logic flush_psr;
      logic we_psr;
      logic we_epc;
      logic we_epsr;
      logic we_elsa;
      logic we_sr;
      // Scratch writes pick the register from here
      epu_msr_pkg::msr_off_t bank_off;
   } commit_ctl_t;

endpackage

//--- hw/epu_msr_decode.sv
// EPU stage-one decoder
// Forms the MSR address, reads the MSR banks and decodes writes and exceptions
`timescale 1ns/1ps

module epu_msr_decode
#(
   parameter int DATA_W = 32,
   parameter int SR_NUM = 4
)
(
   input  logic                          ex_valid,
   input  logic                          flush_s1,
   input  epu_exc_pkg::epu_opc_t         ex_opc,
   input  logic [DATA_W-1:0]             ex_operand1,
   input  logic [DATA_W-1:0]             ex_operand2,
   input  logic [DATA_W-1:0]             ex_imm,
   input  epu_msr_pkg::psr_t             msr_psr,
   input  epu_msr_pkg::psr_t             msr_epsr,
   input  logic [DATA_W-1:0]             msr_cpuid,
   input  logic [DATA_W-1:0]             msr_epc,
   input  logic [DATA_W-1:0]             msr_elsa,
   input  logic [DATA_W-1:0]             msr_coreid,
   input  logic [SR_NUM*DATA_W-1:0]      msr_sr,
   output logic [DATA_W-1:0]             epu_dout,
   output logic                          epu_dout_valid,
   output epu_exc_pkg::commit_ctl_t      s1_ctl,
   output logic [DATA_W-1:0]             s1_wdat
);

   logic [DATA_W-1:0]         msr_addr;
   epu_msr_pkg::msr_bank_t    bank;
   epu_msr_pkg::msr_off_t     off;
   logic                      bank_ps;
   logic                      bank_sr;
   logic                      live;
   logic                      wmsr;
   logic [DATA_W-1:0]         dout_ps;
   logic [DATA_W-1:0]         dout_sr;

   // Operand1 plus the immediate gives the MSR address
   assign msr_addr = ex_operand1 |
                     {{(DATA_W-epu_msr_pkg::MSR_IMM_W){1'b0}},
                      ex_imm[epu_msr_pkg::MSR_IMM_W-1:0]};
   assign bank = msr_addr[epu_msr_pkg::BANK_AW+epu_msr_pkg::BANK_OFF_AW-1 :
                          epu_msr_pkg::BANK_OFF_AW];
   assign off = msr_addr[epu_msr_pkg::BANK_OFF_AW-1:0];

   assign bank_ps = (bank == epu_msr_pkg::BANK_PS);
   assign bank_sr = (bank == epu_msr_pkg::BANK_SR);

   // PSR and EPSR are zero-extended to the word
   assign dout_ps =
      ({DATA_W{off[epu_msr_pkg::OFF_PSR]}} &
       {{(DATA_W-epu_msr_pkg::PSR_W){1'b0}}, msr_psr}) |
      ({DATA_W{off[epu_msr_pkg::OFF_CPUID]}} & msr_cpuid) |
      ({DATA_W{off[epu_msr_pkg::OFF_EPSR]}} &
       {{(DATA_W-epu_msr_pkg::PSR_W){1'b0}}, msr_epsr}) |
      ({DATA_W{off[epu_msr_pkg::OFF_EPC]}} & msr_epc) |
      ({DATA_W{off[epu_msr_pkg::OFF_ELSA]}} & msr_elsa) |
      ({DATA_W{off[epu_msr_pkg::OFF_COREID]}} & msr_coreid);

   // Scratch registers, low offset bits select one-hot
   always_comb
   begin
      dout_sr = '0;
      for (int i = 0; i < SR_NUM; i++)
      begin
         dout_sr = dout_sr | ({DATA_W{off[i]}} & msr_sr[i*DATA_W +: DATA_W]);
      end
   end

   // Unknown banks fall through as zero
   assign epu_dout = ({DATA_W{bank_ps}} & dout_ps) |
                     ({DATA_W{bank_sr}} & dout_sr);

   assign live = ex_valid & ~flush_s1;
   assign wmsr = live & ex_opc[epu_exc_pkg::OPC_WMSR];

   assign epu_dout_valid = live & ex_opc[epu_exc_pkg::OPC_RMSR];

   always_comb
   begin
      s1_ctl = '0;
      s1_ctl.eret = live & ex_opc[epu_exc_pkg::OPC_ERET];
      s1_ctl.esyscall = live & ex_opc[epu_exc_pkg::OPC_ESYSCALL];
      s1_ctl.einsn = live & ex_opc[epu_exc_pkg::OPC_EINSN];
      s1_ctl.eirq = live & ex_opc[epu_exc_pkg::OPC_EIRQ];
      s1_ctl.we_psr = wmsr & bank_ps & off[epu_msr_pkg::OFF_PSR];
      s1_ctl.we_epc = wmsr & bank_ps & off[epu_msr_pkg::OFF_EPC];
      s1_ctl.we_epsr = wmsr & bank_ps & off[epu_msr_pkg::OFF_EPSR];
      s1_ctl.we_elsa = wmsr & bank_ps & off[epu_msr_pkg::OFF_ELSA];
      s1_ctl.we_sr = wmsr & bank_sr;
      // Only PSR writes trigger the TLB flush now
      s1_ctl.flush_psr = s1_ctl.we_psr;
      s1_ctl.bank_off = live ? off : '0;
   end

   assign s1_wdat = ex_operand2;

   // Upstream decode never issues two EPU operations at once
   a_opc_onehot: assert final (!ex_valid || $onehot0(ex_opc));

endmodule

//--- hw/epu_commit_reg.sv
// EPU stage-one to stage-two commit register
// Control resets and takes flush loads, payload follows the stage enable
`timescale 1ns/1ps

module epu_commit_reg
#(
   parameter int DATA_W = 32
)
(
   input  logic                          clk,
   input  logic                          rst,
   input  logic                          p_ce_s1,
   input  logic                          flush_s1,
   input  epu_exc_pkg::commit_ctl_t      s1_ctl,
   input  logic [DATA_W-1:0]             s1_wdat,
   input  logic [DATA_W-3:0]             ex_pc,
   input  logic [DATA_W-3:0]             ex_npc,
   output epu_exc_pkg::commit_ctl_t      s2_ctl,
   output logic [DATA_W-1:0]             s2_wdat,
   output logic [DATA_W-3:0]             s2_pc,
   output logic [DATA_W-3:0]             s2_npc
);

   localparam int PC_W = DATA_W - 2;

   logic ctl_load;

   // A flush loads the already cleared control word
   assign ctl_load = p_ce_s1 | flush_s1;

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         s2_ctl <= '0;
      end
      else if (ctl_load)
      begin
         s2_ctl <= s1_ctl;
      end
   end

   always_ff @(posedge clk)
   begin
      if (p_ce_s1)
      begin
         s2_wdat <= s1_wdat;
         s2_pc <= ex_pc[PC_W-1:0];
         s2_npc <= ex_npc[PC_W-1:0];
      end
   end

   // Decoder clears every field of a flushed instruction
   a_ctl_flush: assert property (@(posedge clk)
      (flush_s1 && !rst) |=> (s2_ctl == '0));

endmodule

//--- hw/epu_exc_commit.sv
// EPU stage-two commit and exception logic
// Commits MSR writes, updates EPC and ELSA, raises the pipeline flush
`timescale 1ns/1ps

module epu_exc_commit
#(
   parameter int                DATA_W = 32,
   parameter int                SR_NUM = 4,
   parameter logic [DATA_W-1:0] SYSCALL_VECTOR = '0,
   parameter logic [DATA_W-1:0] INSN_VECTOR = '0,
   parameter logic [DATA_W-1:0] IRQ_VECTOR = '0,
   parameter logic [DATA_W-1:0] ALIGN_VECTOR = '0
)
(
   input  logic                          p_ce_s2,
   input  epu_exc_pkg::commit_ctl_t      s2_ctl,
   input  logic [DATA_W-1:0]             s2_wdat,
   input  logic [DATA_W-3:0]             s2_pc,
   input  logic [DATA_W-3:0]             s2_npc,
   input  logic                          s2_ealign,
   input  logic [DATA_W-1:0]             s2_vaddr,
   input  logic [DATA_W-1:0]             msr_epc,
   output logic                          exc_flush,
   output logic [DATA_W-3:0]             exc_flush_tgt,
   output logic                          msr_psr_save,
   output logic                          msr_psr_restore,
   output logic [epu_msr_pkg::PSR_DCE-epu_msr_pkg::PSR_RM:0] msr_psr_nxt,
   output logic                          msr_psr_we,
   output logic [DATA_W-1:0]             msr_epc_nxt,
   output logic                          msr_epc_we,
   output epu_msr_pkg::psr_t             msr_epsr_nxt,
   output logic                          msr_epsr_we,
   output logic [DATA_W-1:0]             msr_elsa_nxt,
   output logic                          msr_elsa_we,
   output logic [DATA_W-1:0]             msr_sr_nxt,
   output logic [SR_NUM-1:0]             msr_sr_we
);

   localparam int PC_W = DATA_W - 2;

   epu_exc_pkg::commit_ctl_t  ctl;
   logic                      ealign;

   // Nothing commits while stage two is stalled
   assign ctl = p_ce_s2 ? s2_ctl : '0;
   assign ealign = p_ce_s2 & s2_ealign;

   assign msr_psr_save = ctl.esyscall | ctl.einsn | ctl.eirq | ealign;
   assign msr_psr_restore = ctl.eret;

   // PSR fields
   assign msr_psr_we = ctl.we_psr;
   assign msr_psr_nxt = {s2_wdat[epu_msr_pkg::PSR_DCE],
                         s2_wdat[epu_msr_pkg::PSR_ICE],
                         s2_wdat[epu_msr_pkg::PSR_DMME],
                         s2_wdat[epu_msr_pkg::PSR_IMME],
                         s2_wdat[epu_msr_pkg::PSR_IRE],
                         s2_wdat[epu_msr_pkg::PSR_RM]};

   assign msr_epsr_we = ctl.we_epsr;
   assign msr_epsr_nxt = s2_wdat[epu_msr_pkg::PSR_W-1:0];

   // A syscall returns past itself, other exceptions retry the instruction
   assign msr_epc_nxt = ctl.we_epc ? s2_wdat :
                        ctl.esyscall ? {s2_npc, 2'b00} :
                        {s2_pc, 2'b00};
   assign msr_epc_we = msr_psr_save | ctl.we_epc;

   // Illegal instruction records its own address
   assign msr_elsa_nxt = ctl.einsn ? {s2_pc, 2'b00} :
                         ealign ? s2_vaddr :
                         s2_wdat;
   assign msr_elsa_we = ctl.einsn | ealign | ctl.we_elsa;

   assign msr_sr_nxt = s2_wdat;
   assign msr_sr_we = ctl.bank_off[SR_NUM-1:0] & {SR_NUM{ctl.we_sr}};

   // Sources are exclusive so the target is a plain AND-OR
   assign exc_flush_tgt =
      ({PC_W{ctl.esyscall}} & SYSCALL_VECTOR[DATA_W-1:2]) |
      ({PC_W{ctl.einsn}} & INSN_VECTOR[DATA_W-1:2]) |
      ({PC_W{ctl.eirq}} & IRQ_VECTOR[DATA_W-1:2]) |
      ({PC_W{ealign}} & ALIGN_VECTOR[DATA_W-1:2]) |
      ({PC_W{ctl.eret}} & msr_epc[DATA_W-1:2]) |
      ({PC_W{ctl.flush_psr}} & s2_npc);

   assign exc_flush = ctl.esyscall | ctl.einsn | ctl.eirq | ctl.eret |
                      ctl.flush_psr | ealign;

   // Stage-two data faults never coincide with a held stage-one exception
   a_one_source: assert final ($countones({ctl.esyscall, ctl.einsn, ctl.eirq,
      ctl.eret, ctl.flush_psr, ealign}) <= 1);

endmodule

//--- hw/epu_top.sv
// Exception and MSR unit of the execute stage
// Stage-one decode, commit register and stage-two commit logic
`timescale 1ns/1ps

module epu_top
#(
   parameter int                DATA_W = 32,
   parameter int                SR_NUM = 4,
   parameter logic [DATA_W-1:0] SYSCALL_VECTOR = 'h100,
   parameter logic [DATA_W-1:0] INSN_VECTOR = 'h200,
   parameter logic [DATA_W-1:0] IRQ_VECTOR = 'h300,
   parameter logic [DATA_W-1:0] ALIGN_VECTOR = 'h400
)
(
   input  logic                          clk,
   input  logic                          rst,
   input  logic                          p_ce_s1,
   input  logic                          p_ce_s2,
   input  logic                          flush_s1,
   input  logic                          ex_valid,
   input  epu_exc_pkg::epu_opc_t         ex_opc,
   input  logic [DATA_W-1:0]             ex_operand1,
   input  logic [DATA_W-1:0]             ex_operand2,
   input  logic [DATA_W-1:0]             ex_imm,
   input  logic [DATA_W-3:0]             ex_pc,
   input  logic [DATA_W-3:0]             ex_npc,
   input  logic                          s2_ealign,
   input  logic [DATA_W-1:0]             s2_vaddr,
   input  epu_msr_pkg::psr_t             msr_psr,
   input  epu_msr_pkg::psr_t             msr_epsr,
   input  logic [DATA_W-1:0]             msr_cpuid,
   input  logic [DATA_W-1:0]             msr_epc,
   input  logic [DATA_W-1:0]             msr_elsa,
   input  logic [DATA_W-1:0]             msr_coreid,
   input  logic [SR_NUM*DATA_W-1:0]      msr_sr,
   output logic [DATA_W-1:0]             epu_dout,
   output logic                          epu_dout_valid,
   output logic                          exc_flush,
   output logic [DATA_W-3:0]             exc_flush_tgt,
   output logic                          msr_psr_save,
   output logic                          msr_psr_restore,
   output logic [epu_msr_pkg::PSR_DCE-epu_msr_pkg::PSR_RM:0] msr_psr_nxt,
   output logic                          msr_psr_we,
   output logic [DATA_W-1:0]             msr_epc_nxt,
   output logic                          msr_epc_we,
   output epu_msr_pkg::psr_t             msr_epsr_nxt,
   output logic                          msr_epsr_we,
   output logic [DATA_W-1:0]             msr_elsa_nxt,
   output logic                          msr_elsa_we,
   output logic [DATA_W-1:0]             msr_sr_nxt,
   output logic [SR_NUM-1:0]             msr_sr_we
);

   epu_exc_pkg::commit_ctl_t  s1_ctl;
   logic [DATA_W-1:0]         s1_wdat;
   epu_exc_pkg::commit_ctl_t  s2_ctl;
   logic [DATA_W-1:0]         s2_wdat;
   logic [DATA_W-3:0]         s2_pc;
   logic [DATA_W-3:0]         s2_npc;

   epu_msr_decode #(.DATA_W(DATA_W), .SR_NUM(SR_NUM)) u_decode (
      .ex_valid       (ex_valid),
      .flush_s1       (flush_s1),
      .ex_opc         (ex_opc),
      .ex_operand1    (ex_operand1),
      .ex_operand2    (ex_operand2),
      .ex_imm         (ex_imm),
      .msr_psr        (msr_psr),
      .msr_epsr       (msr_epsr),
      .msr_cpuid      (msr_cpuid),
      .msr_epc        (msr_epc),
      .msr_elsa       (msr_elsa),
      .msr_coreid     (msr_coreid),
      .msr_sr         (msr_sr),
      .epu_dout       (epu_dout),
      .epu_dout_valid (epu_dout_valid),
      .s1_ctl         (s1_ctl),
      .s1_wdat        (s1_wdat)
   );

   epu_commit_reg #(.DATA_W(DATA_W)) u_commit_reg (
      .clk      (clk),
      .rst      (rst),
      .p_ce_s1  (p_ce_s1),
      .flush_s1 (flush_s1),
      .s1_ctl   (s1_ctl),
      .s1_wdat  (s1_wdat),
      .ex_pc    (ex_pc),
      .ex_npc   (ex_npc),
      .s2_ctl   (s2_ctl),
      .s2_wdat  (s2_wdat),
      .s2_pc    (s2_pc),
      .s2_npc   (s2_npc)
   );

   epu_exc_commit #(
      .DATA_W         (DATA_W),
      .SR_NUM         (SR_NUM),
      .SYSCALL_VECTOR (SYSCALL_VECTOR),
      .INSN_VECTOR    (INSN_VECTOR),
      .IRQ_VECTOR     (IRQ_VECTOR),
      .ALIGN_VECTOR   (ALIGN_VECTOR)
   ) u_exc_commit (
      .p_ce_s2         (p_ce_s2),
      .s2_ctl          (s2_ctl),
      .s2_wdat         (s2_wdat),
      .s2_pc           (s2_pc),
      .s2_npc          (s2_npc),
      .s2_ealign       (s2_ealign),
      .s2_vaddr        (s2_vaddr),
      .msr_epc         (msr_epc),
      .exc_flush       (exc_flush),
      .exc_flush_tgt   (exc_flush_tgt),
      .msr_psr_save    (msr_psr_save),
      .msr_psr_restore (msr_psr_restore),
      .msr_psr_nxt     (msr_psr_nxt),
      .msr_psr_we      (msr_psr_we),
      .msr_epc_nxt     (msr_epc_nxt),
      .msr_epc_we      (msr_epc_we),
      .msr_epsr_nxt    (msr_epsr_nxt),
      .msr_epsr_we     (msr_epsr_we),
      .msr_elsa_nxt    (msr_elsa_nxt),
      .msr_elsa_we     (msr_elsa_we),
      .msr_sr_nxt      (msr_sr_nxt),
      .msr_sr_we       (msr_sr_we)
   );

endmodule

//--- testbench/tb_epu.sv
// Testbench for the EPU exception and MSR unit
// Directed tests of MSR reads, writes, exceptions and stage control
`timescale 1ns/1ps

module tb_epu;

   localparam int DATA_W = 32;
   localparam int SR_NUM = 4;
   localparam int PC_W = DATA_W - 2;
   localparam int FLD_W = epu_msr_pkg::PSR_DCE - epu_msr_pkg::PSR_RM + 1;
   localparam logic [DATA_W-1:0] SYSCALL_VEC = 32'h0000_0100;
   localparam logic [DATA_W-1:0] INSN_VEC = 32'h0000_0204;
   localparam logic [DATA_W-1:0] IRQ_VEC = 32'h0000_0308;
   localparam logic [DATA_W-1:0] ALIGN_VEC = 32'h0000_040c;
   // Reset plus all tests take about 60 cycles, limit leaves wide margin
   localparam int CYCLE_LIMIT = 200;

   logic clk = 1'b0;
   logic rst, p_ce_s1, p_ce_s2, flush_s1, ex_valid, s2_ealign;
   epu_exc_pkg::epu_opc_t ex_opc;
   logic [DATA_W-1:0] ex_operand1, ex_operand2, ex_imm, s2_vaddr;
   logic [PC_W-1:0] ex_pc, ex_npc;
   epu_msr_pkg::psr_t msr_psr, msr_epsr;
   logic [DATA_W-1:0] msr_cpuid, msr_epc, msr_elsa, msr_coreid;
   logic [SR_NUM*DATA_W-1:0] msr_sr;
   logic [DATA_W-1:0] epu_dout, msr_epc_nxt, msr_elsa_nxt, msr_sr_nxt;
   logic epu_dout_valid, exc_flush, msr_psr_save, msr_psr_restore;
   logic msr_psr_we, msr_epc_we, msr_epsr_we, msr_elsa_we;
   logic [PC_W-1:0] exc_flush_tgt;
   logic [FLD_W-1:0] msr_psr_nxt;
   epu_msr_pkg::psr_t msr_epsr_nxt;
   logic [SR_NUM-1:0] msr_sr_we;
   integer seed = 32'he2a1_9a1b;
   int cycle_count = 0;

   epu_top #(
      .DATA_W(DATA_W), .SR_NUM(SR_NUM),
      .SYSCALL_VECTOR(SYSCALL_VEC), .INSN_VECTOR(INSN_VEC),
      .IRQ_VECTOR(IRQ_VEC), .ALIGN_VECTOR(ALIGN_VEC)
   ) DUT (.*);

   always #20 clk = ~clk;

   always @(posedge clk)
   begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= CYCLE_LIMIT)
      begin
         $display("Timeout: the test sequence did not finish in %0d cycles", CYCLE_LIMIT);
         abort_run();
      end
   end

   task automatic abort_run();
      $display(">>> FAIL");
      $fatal(1, "Simulation stopped at the first error");
   endtask

   task automatic check_word(input logic [DATA_W-1:0] got, exp, input string what);
      if (got !== exp)
      begin
         $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
         abort_run();
      end
   endtask

   task automatic check_pc(input logic [PC_W-1:0] got, exp, input string what);
      if (got !== exp)
      begin
         $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
         abort_run();
      end
   endtask

   task automatic check_psr(input epu_msr_pkg::psr_t got, exp, input string what);
      if (got !== exp)
      begin
         $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
         abort_run();
      end
   endtask

   task automatic check_fields(input logic [FLD_W-1:0] got, exp, input string what);
      if (got !== exp)
      begin
         $display("CHECK FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
         abort_run();
      end
   endtask

   task automatic check_mask(input logic [SR_NUM-1:0] got, exp, input string what);
      if (got !== exp)
      begin
         $display("CHECK FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
         abort_run();
      end
   endtask

   task automatic check_bit(input logic got, exp, input string what);
      if (got !== exp)
      begin
         $display("CHECK FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
         abort_run();
      end
   endtask

   function automatic epu_exc_pkg::epu_opc_t opc_bit(input int pos);
      opc_bit = '0;
      opc_bit[pos] = 1'b1;
   endfunction

   // Bank number sits right above the offset field
   function automatic logic [DATA_W-1:0] msr_address(input int bank, input int bit_pos);
      msr_address = (bank << epu_msr_pkg::BANK_OFF_AW) | (1 << bit_pos);
   endfunction

   task automatic step();
      @(posedge clk);
      #2;
   endtask

   task automatic go_idle();
      ex_valid = 1'b0;
      ex_opc = '0;
      flush_s1 = 1'b0;
   endtask

   // Bank bits go in operand1, offset in the immediate with ignored upper bits
   task automatic issue(input epu_exc_pkg::epu_opc_t opc, input logic [DATA_W-1:0] addr,
                        input logic [DATA_W-1:0] wdat, input logic [PC_W-1:0] pc);
      ex_valid = 1'b1;
      ex_opc = opc;
      ex_operand1 = addr & ~32'h1ff;
      ex_imm = (addr & 32'h1ff) | 32'hfff8_0000;
      ex_operand2 = wdat;
      ex_pc = pc;
      ex_npc = pc + 1'b1;
   endtask

   // Instruction crosses into stage two, outputs sampled mid-cycle
   task automatic to_stage_two();
      step();
      go_idle();
      #10;
   endtask

   task automatic check_quiet(input string what);
      check_bit(exc_flush, 1'b0, {what, ": exc_flush"});
      check_bit(msr_psr_save, 1'b0, {what, ": msr_psr_save"});
      check_bit(msr_psr_restore, 1'b0, {what, ": msr_psr_restore"});
      check_bit(msr_psr_we | msr_epsr_we, 1'b0, {what, ": PSR/EPSR write"});
      check_bit(msr_epc_we | msr_elsa_we, 1'b0, {what, ": EPC/ELSA write"});
      check_mask(msr_sr_we, '0, {what, ": msr_sr_we"});
   endtask

   task automatic test_reads();
      logic [DATA_W-1:0] exp_ps [6];
      exp_ps[epu_msr_pkg::OFF_PSR] = {{(DATA_W-epu_msr_pkg::PSR_W){1'b0}}, msr_psr};
      exp_ps[epu_msr_pkg::OFF_CPUID] = msr_cpuid;
      exp_ps[epu_msr_pkg::OFF_EPSR] = {{(DATA_W-epu_msr_pkg::PSR_W){1'b0}}, msr_epsr};
      exp_ps[epu_msr_pkg::OFF_EPC] = msr_epc;
      exp_ps[epu_msr_pkg::OFF_ELSA] = msr_elsa;
      exp_ps[epu_msr_pkg::OFF_COREID] = msr_coreid;
      for (int k = 0; k < 6; k++)
      begin
         issue(opc_bit(epu_exc_pkg::OPC_RMSR), msr_address(0, k), '0, '0);
         #10;
         check_word(epu_dout, exp_ps[k], "PS bank read");
         check_bit(epu_dout_valid, 1'b1, "epu_dout_valid");
         step();
      end
      for (int k = 0; k < SR_NUM; k++)
      begin
         issue(opc_bit(epu_exc_pkg::OPC_RMSR), msr_address(8, k), '0, '0);
         #10;
         check_word(epu_dout, msr_sr[k*DATA_W +: DATA_W], "scratch read");
         check_bit(epu_dout_valid, 1'b1, "epu_dout_valid");
         step();
      end
      issue(opc_bit(epu_exc_pkg::OPC_RMSR), msr_address(3, 0), '0, '0);
      #10;
      check_word(epu_dout, '0, "unknown bank read");
      go_idle();
      step();
   endtask

   task automatic test_writes();
      logic [DATA_W-1:0] data;
      data = $random(seed);
      issue(opc_bit(epu_exc_pkg::OPC_WMSR), msr_address(0, epu_msr_pkg::OFF_EPC), data, 7);
      to_stage_two();
      check_bit(msr_epc_we, 1'b1, "msr_epc_we");
      check_word(msr_epc_nxt, data, "msr_epc_nxt");
      check_bit(exc_flush, 1'b0, "exc_flush on EPC write");
      step();
      for (int k = 0; k < SR_NUM; k++)
      begin
         data = $random(seed);
         issue(opc_bit(epu_exc_pkg::OPC_WMSR), msr_address(8, k), data, 9);
         to_stage_two();
         check_mask(msr_sr_we, SR_NUM'(1 << k), "msr_sr_we");
         check_word(msr_sr_nxt, data, "msr_sr_nxt");
         step();
      end
      data = $random(seed);
      issue(opc_bit(epu_exc_pkg::OPC_WMSR), msr_address(0, epu_msr_pkg::OFF_EPSR), data, 3);
      to_stage_two();
      check_bit(msr_epsr_we, 1'b1, "msr_epsr_we");
      check_psr(msr_epsr_nxt, data[epu_msr_pkg::PSR_W-1:0], "msr_epsr_nxt");
      step();
   endtask

   task automatic test_psr_write();
      logic [DATA_W-1:0] data;
      logic [PC_W-1:0] pc;
      data = $random(seed);
      pc = $random(seed);
      issue(opc_bit(epu_exc_pkg::OPC_WMSR), msr_address(0, epu_msr_pkg::OFF_PSR), data, pc);
      to_stage_two();
      check_bit(msr_psr_we, 1'b1, "msr_psr_we");
      check_fields(msr_psr_nxt, data[epu_msr_pkg::PSR_DCE:epu_msr_pkg::PSR_RM], "PSR fields");
      check_bit(exc_flush, 1'b1, "exc_flush on PSR write");
      check_pc(exc_flush_tgt, pc + 1'b1, "PSR flush target");
      check_bit(msr_psr_save, 1'b0, "msr_psr_save on PSR write");
      step();
   endtask

   // One exception through both stages, checks common to all of them
   task automatic raise(input int opc_pos, input logic [PC_W-1:0] pc,
                        input logic [PC_W-1:0] tgt, input logic save);
      issue(opc_bit(opc_pos), '0, '0, pc);
      to_stage_two();
      check_bit(exc_flush, 1'b1, "exception exc_flush");
      check_pc(exc_flush_tgt, tgt, "exception flush target");
      check_bit(msr_psr_save, save, "exception msr_psr_save");
      check_bit(msr_psr_restore, ~save, "exception msr_psr_restore");
   endtask

   task automatic test_exceptions();
      logic [PC_W-1:0] pc;
      pc = $random(seed);
      raise(epu_exc_pkg::OPC_ESYSCALL, pc, SYSCALL_VEC[DATA_W-1:2], 1'b1);
      check_bit(msr_epc_we, 1'b1, "syscall msr_epc_we");
      check_word(msr_epc_nxt, {pc + 1'b1, 2'b00}, "syscall msr_epc_nxt");
      step();
      pc = $random(seed);
      raise(epu_exc_pkg::OPC_EINSN, pc, INSN_VEC[DATA_W-1:2], 1'b1);
      check_bit(msr_elsa_we, 1'b1, "illegal insn msr_elsa_we");
      check_word(msr_elsa_nxt, {pc, 2'b00}, "illegal insn msr_elsa_nxt");
      check_word(msr_epc_nxt, {pc, 2'b00}, "illegal insn msr_epc_nxt");
      step();
      raise(epu_exc_pkg::OPC_EIRQ, $random(seed), IRQ_VEC[DATA_W-1:2], 1'b1);
      step();
      raise(epu_exc_pkg::OPC_ERET, $random(seed), msr_epc[DATA_W-1:2], 1'b0);
      step();
   endtask

   task automatic test_align();
      logic [DATA_W-1:0] vaddr;
      vaddr = $random(seed);
      s2_ealign = 1'b1;
      s2_vaddr = vaddr;
      #10;
      check_bit(exc_flush, 1'b1, "align exc_flush");
      check_pc(exc_flush_tgt, ALIGN_VEC[DATA_W-1:2], "align flush target");
      check_word(msr_elsa_nxt, vaddr, "align msr_elsa_nxt");
      check_bit(msr_psr_save, 1'b1, "align msr_psr_save");
      step();
      s2_ealign = 1'b0;
   endtask

   task automatic test_flush_stall();
      logic [PC_W-1:0] pc;
      issue(opc_bit(epu_exc_pkg::OPC_ESYSCALL), '0, '0, 5);
      flush_s1 = 1'b1;
      to_stage_two();
      check_quiet("flushed syscall");
      step();
      pc = $random(seed);
      issue(opc_bit(epu_exc_pkg::OPC_ESYSCALL), '0, '0, pc);
      p_ce_s2 = 1'b0;
      step();
      go_idle();
      p_ce_s1 = 1'b0;
      repeat (3)
      begin
         #10;
         check_quiet("stalled syscall");
         step();
      end
      p_ce_s2 = 1'b1;
      #10;
      check_bit(exc_flush, 1'b1, "released syscall exc_flush");
      check_pc(exc_flush_tgt, SYSCALL_VEC[DATA_W-1:2], "released syscall target");
      check_word(msr_epc_nxt, {pc + 1'b1, 2'b00}, "released syscall msr_epc_nxt");
      p_ce_s1 = 1'b1;
      step();
      #10;
      check_quiet("after released syscall");
   endtask

   initial
   begin
      rst = 1'b1;
      p_ce_s1 = 1'b0;
      p_ce_s2 = 1'b0;
      go_idle();
      ex_operand1 = '0;
      ex_operand2 = '0;
      ex_imm = '0;
      ex_pc = '0;
      ex_npc = '0;
      s2_ealign = 1'b0;
      s2_vaddr = '0;
      msr_psr = $random(seed);
      msr_epsr = $random(seed);
      msr_cpuid = $random(seed);
      msr_epc = $random(seed);
      msr_elsa = $random(seed);
      msr_coreid = $random(seed);
      msr_sr = {$random(seed), $random(seed), $random(seed), $random(seed)};
      repeat (8) @(posedge clk);
      #2;
      rst = 1'b0;
      p_ce_s1 = 1'b1;
      p_ce_s2 = 1'b1;
      #10;
      check_quiet("after reset");
      step();
      test_reads();
      test_writes();
      test_psr_write();
      test_exceptions();
      test_align();
      test_flush_stall();
      $display(">>> PASS");
      $finish;
   end

endmodule

//--- filelist.f
hw/epu_msr_pkg.sv
hw/epu_exc_pkg.sv
hw/epu_msr_decode.sv
hw/epu_commit_reg.sv
hw/epu_exc_commit.sv
hw/epu_top.sv
testbench/tb_epu.sv

//--- Bender.yml
package:
  name: epu_exc

sources:
  - hw/epu_msr_pkg.sv
  - hw/epu_exc_pkg.sv
  - hw/epu_msr_decode.sv
  - hw/epu_commit_reg.sv
  - hw/epu_exc_commit.sv
  - hw/epu_top.sv
  - target: test
    files:
      - testbench/tb_epu.sv
